/* sim.f */
source/dcache_pkg.sv
source/dcache_lookup.sv
source/dcache_ctrl.sv
source/dcache_ways.sv
source/dcache.sv
test/dcache_chk.sv
test/dcache_monitor.sv
test/tb_dcache.sv

/* source/dcache.sv */
`timescale 1ns/1ps

module dcache import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	// datapath side
	input logic dmemREN,
	input logic dmemWEN,
	input word_t dmemaddr,
	input word_t dmemstore,
	input logic halt,
	output logic dhit,
	output word_t dmemload,
	output logic flushed,
	// memory side
	input logic dwait,
	input word_t dload,
	output logic dREN,
	output logic dWEN,
	output word_t daddr,
	output word_t dstore
);

	cache_addr_u addr;
	logic hit, hit_way;
	logic victim_way, victim_dirty;
	tag_t victim_tag, scan_tag;
	logic scan_dirty;
	logic hit_en, store_en;
	logic fill_en, fill_done, fill_way;
	logic clean_en, word_sel;
	logic sel_way;
	idx_t sel_idx;

	assign addr.word = dmemaddr;

	dcache_lookup u_lookup (
		.CLK(CLK),
		.nRST(nRST),
		.addr(addr),
		.hit_en(hit_en),
		.store_en(store_en),
		.fill_done(fill_done),
		.fill_way(fill_way),
		.clean_en(clean_en),
		.clean_way(sel_way),  // flush slot under write back
		.clean_idx(sel_idx),
		.scan_way(sel_way),
		.scan_idx(sel_idx),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.scan_tag(scan_tag),
		.scan_dirty(scan_dirty)
	);

	dcache_ctrl u_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.dmemREN(dmemREN),
		.dmemWEN(dmemWEN),
		.halt(halt),
		.dwait(dwait),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.scan_tag(scan_tag),
		.scan_dirty(scan_dirty),
		.addr(addr),
		.dhit(dhit),
		.dREN(dREN),
		.dWEN(dWEN),
		.daddr(daddr),
		.hit_en(hit_en),
		.store_en(store_en),
		.fill_en(fill_en),
		.fill_done(fill_done),
		.fill_way(fill_way),
		.clean_en(clean_en),
		.word_sel(word_sel),
		.flushed(flushed),
		.sel_way(sel_way),
		.sel_idx(sel_idx)
	);

	dcache_ways u_ways (
		.CLK(CLK),
		.nRST(nRST),
		.addr(addr),
		.dmemstore(dmemstore),
		.dload(dload),
		.store_en(store_en),
		.hit_way(hit_way),
		.fill_en(fill_en),
		.sel_way(sel_way),
		.sel_idx(sel_idx),
		.word_sel(word_sel),
		.dmemload(dmemload),
		.dstore(dstore)
	);

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic dmemREN,
	input logic dmemWEN,
	input logic halt,
	input logic dwait,
	input logic hit,
	input logic hit_way,
	input logic victim_way,
	input logic victim_dirty,
	input tag_t victim_tag,
	input tag_t scan_tag,
	input logic scan_dirty,
	input cache_addr_u addr,
	output logic dhit,
	output logic dREN,
	output logic dWEN,
	output word_t daddr,
	output logic hit_en,
	output logic store_en,
	output logic fill_en,
	output logic fill_done,
	output logic fill_way,
	output logic clean_en,
	output logic word_sel,
	output logic flushed,
	output logic sel_way,
	output idx_t sel_idx
);

	ctrl_state_t state, next_state;
	logic [4:0] slot, next_slot;  // flush slot, bit 3 is the way
	logic flushing;

	// word address of one word of a block
	function automatic word_t block_addr(tag_t tag, idx_t idx, logic word);
		cache_addr_u a;
		a.f.tag = tag;
		a.f.idx = idx;
		a.f.blkoff = word;
		a.f.bytoff = 2'b00;
		return a.word;
	endfunction

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
			slot <= '0;
		end else begin
			state <= next_state;
			slot <= next_slot;
		end
	end

	assign flushed = (state == HALTED);
	assign fill_way = victim_way;  // lru does not move during a miss
	assign flushing = (state == FLUSH_SCAN) || (state == FLUSH0) || (state == FLUSH1);

	// which stored word the arrays write or present
	always_comb begin
		if (flushing) begin
			sel_way = slot[3];
			sel_idx = slot[2:0];
		end else begin
			sel_way = (state == IDLE && hit) ? hit_way : victim_way;
			sel_idx = addr.f.idx;
		end
	end

	always_comb begin
		next_state = state;
		next_slot = slot;
		dhit = 1'b0;
		dREN = 1'b0;
		dWEN = 1'b0;
		daddr = '0;
		hit_en = 1'b0;
		store_en = 1'b0;
		fill_en = 1'b0;
		fill_done = 1'b0;
		clean_en = 1'b0;
		word_sel = 1'b0;

		case (state)
			IDLE: begin
				if (halt) begin  // halt wins over a pending request
					next_state = FLUSH_SCAN;
					next_slot = '0;
				end else if (dmemREN || dmemWEN) begin
					if (hit) begin
						dhit = 1'b1;
						hit_en = 1'b1;
						store_en = dmemWEN;
					end else if (victim_dirty) begin
						next_state = WB0;
					end else begin
						next_state = FILL0;
					end
				end
			end
			WB0: begin
				dWEN = 1'b1;
				daddr = block_addr(victim_tag, addr.f.idx, 1'b0);
				if (!dwait) next_state = WB1;
			end
			WB1: begin
				dWEN = 1'b1;
				word_sel = 1'b1;
				daddr = block_addr(victim_tag, addr.f.idx, 1'b1);
				if (!dwait) next_state = FILL0;
			end
			FILL0: begin
				dREN = 1'b1;
				daddr = block_addr(addr.f.tag, addr.f.idx, 1'b0);
				fill_en = !dwait;
				if (!dwait) next_state = FILL1;
			end
			FILL1: begin
				dREN = 1'b1;
				word_sel = 1'b1;
				daddr = block_addr(addr.f.tag, addr.f.idx, 1'b1);
				fill_en = !dwait;
				fill_done = !dwait;
				// held request hits once back in idle
				if (!dwait) next_state = IDLE;
			end
			FLUSH_SCAN: begin
				if (slot[4]) begin
					next_state = HALTED;  // all 16 slots done
				end else if (scan_dirty) begin
					next_state = FLUSH0;
				end else begin
					next_slot = slot + 5'd1;
				end
			end
			FLUSH0: begin
				dWEN = 1'b1;
				daddr = block_addr(scan_tag, slot[2:0], 1'b0);
				if (!dwait) next_state = FLUSH1;
			end
			FLUSH1: begin
				dWEN = 1'b1;
				word_sel = 1'b1;
				daddr = block_addr(scan_tag, slot[2:0], 1'b1);
				if (!dwait) begin
					clean_en = 1'b1;
					next_slot = slot + 5'd1;
					next_state = FLUSH_SCAN;
				end
			end
			HALTED: begin
				next_state = HALTED;  // stays here until reset
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

/* source/dcache_lookup.sv */
`timescale 1ns/1ps

module dcache_lookup import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input cache_addr_u addr,
	input logic hit_en,
	input logic store_en,
	input logic fill_done,
	input logic fill_way,
	input logic clean_en,
	input logic clean_way,
	input idx_t clean_idx,
	input logic scan_way,
	input idx_t scan_idx,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output logic victim_dirty,
	output tag_t victim_tag,
	output tag_t scan_tag,
	output logic scan_dirty
);

	tag_t tags [2][N_SETS];
	logic [1:0][N_SETS-1:0] valid;
	logic [1:0][N_SETS-1:0] dirty;
	logic [N_SETS-1:0] lru;  // way to replace next in each set
	logic [1:0] match;
	idx_t idx;

	assign idx = addr.f.idx;

	// tag compare in both ways
	assign match[0] = valid[0][idx] && (tags[0][idx] == addr.f.tag);
	assign match[1] = valid[1][idx] && (tags[1][idx] == addr.f.tag);
	assign hit = |match;
	assign hit_way = match[1];

	assign victim_way = lru[idx];
	assign victim_dirty = valid[victim_way][idx] & dirty[victim_way][idx];
	assign victim_tag = tags[victim_way][idx];

	// flush walks the slots independent of the request address
	assign scan_tag = tags[scan_way][scan_idx];
	assign scan_dirty = valid[scan_way][scan_idx] & dirty[scan_way][scan_idx];

	always_ff @(posedge CLK) begin
		if (fill_done) begin
			tags[fill_way][idx] <= addr.f.tag;  // installed with the last fill word
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			if (hit_en) begin
				lru[idx] <= ~hit_way;  // other way is now least recent
			end
			if (store_en) begin
				dirty[hit_way][idx] <= 1'b1;
			end
			if (fill_done) begin
				valid[fill_way][idx] <= 1'b1;
				dirty[fill_way][idx] <= 1'b0;
			end
			if (clean_en) begin
				dirty[clean_way][clean_idx] <= 1'b0;  // block now matches memory
			end
		end
	end

endmodule

/* source/dcache_pkg.sv */
package dcache_pkg;

	// cache geometry, fixed by the address split below
	localparam int N_SETS = 8;
	localparam int IDX_W  = 3;
	localparam int TAG_W  = 26;

	typedef logic [31:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [IDX_W-1:0] idx_t;

	// a cache address seen either as a flat word or as its fields
	typedef union packed {
		word_t word;
		struct packed {
			tag_t tag;
			idx_t idx;
			logic blkoff;        // word within the two-word block
			logic [1:0] bytoff;  // always 0 for word accesses
		} f;
	} cache_addr_u;

	// controller states
	typedef enum logic [3:0] {
		IDLE,
		WB0,         // write back victim word 0
		WB1,         // write back victim word 1
		FILL0,
		FILL1,
		FLUSH_SCAN,  // look at one set/way slot per cycle
		FLUSH0,
		FLUSH1,
		HALTED
	} ctrl_state_t;

endpackage

/* source/dcache_ways.sv */
`timescale 1ns/1ps

module dcache_ways import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input cache_addr_u addr,
	input word_t dmemstore,
	input word_t dload,
	input logic store_en,
	input logic hit_way,
	input logic fill_en,
	input logic sel_way,
	input idx_t sel_idx,
	input logic word_sel,
	output word_t dmemload,
	output word_t dstore
);

	// [way][set][word]
	word_t blk [2][N_SETS][2];
	idx_t idx;
	logic off;

	assign idx = addr.f.idx;
	assign off = addr.f.blkoff;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int w = 0; w < 2; w++) begin
				for (int s = 0; s < N_SETS; s++) begin
					blk[w][s][0] <= '0;
					blk[w][s][1] <= '0;
				end
			end
		end else begin
			// store hit and fill never happen in the same cycle
			if (store_en) begin
				blk[hit_way][idx][off] <= dmemstore;
			end
			if (fill_en) begin
				blk[sel_way][sel_idx][word_sel] <= dload;  // word from memory
			end
		end
	end

	// load word for the datapath, only meaningful with dhit
	assign dmemload = blk[hit_way][idx][off];

	// word going out on a write back or flush
	assign dstore = blk[sel_way][sel_idx][word_sel];

endmodule

/* test/dcache_chk.sv */
`timescale 1ns/1ps

module dcache_chk import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic dREN,
	input logic dWEN,
	input logic dwait,
	input word_t daddr,
	input logic flushed
);

	int fails = 0;

	// the memory port moves one direction at a time
	a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
		else begin
			fails++;
			$error("dREN and dWEN are high in the same cycle");
		end

	a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
		(dwait && (dREN || dWEN)) |=> $stable(daddr))
		else begin
			fails++;
			$error("daddr changed while the memory was stalling the transfer");
		end

	a_flushed_held: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
		else begin
			fails++;
			$error("flushed fell after it had risen");
		end

endmodule

/* test/dcache_monitor.sv */
`timescale 1ns/1ps

module dcache_monitor import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic dhit,
	input logic dmemREN,
	input word_t dmemload,
	input word_t exp_load,
	input logic dWEN,
	input logic dwait,
	input word_t daddr,
	input word_t dstore
);

	localparam int N_WR = 8;

	// memory writes in the order they must appear
	word_t wr_addr [N_WR] = '{
		32'h018, 32'h01c,
		32'h008, 32'h00c,
		32'h010, 32'h014,
		32'h090, 32'h094
	};
	word_t wr_data [N_WR] = '{
		32'hd00d_0000, 32'hd00d_0004,                 // eviction of the set 3 block
		32'h5a5a_0000 ^ 32'h008, 32'hcafe_0001,       // flush of set 1 way 0
		32'h5a5a_0000 ^ 32'h010, 32'hbeef_0014,       // flush of set 2 way 0
		32'h5a5a_0000 ^ 32'h090, 32'hc0c0_0094        // flush of set 2 way 1
	};
	int wr_cnt = 0;
	int load_errs = 0;
	int wr_errs = 0;

	always @(posedge CLK) begin
		if (nRST) begin
			if (dhit && dmemREN && (dmemload !== exp_load)) begin
				load_errs++;
				$display("Error dmemload expected %h got %h", exp_load, dmemload);
			end
			if (dWEN && !dwait) begin  // transfer accepted this cycle
				if (wr_cnt >= N_WR) begin
					wr_errs++;
					$display("memory write to %h was not expected", daddr);
				end else begin
					if (daddr !== wr_addr[wr_cnt]) begin
						wr_errs++;
						$display("Error daddr expected %h got %h", wr_addr[wr_cnt], daddr);
					end
					if (dstore !== wr_data[wr_cnt]) begin
						wr_errs++;
						$display("Error dstore expected %h got %h", wr_data[wr_cnt], dstore);
					end
				end
				wr_cnt++;
			end
		end
	end

	// missing writes only show at the end of the run
	task automatic check_end();
		if (wr_cnt != N_WR) begin
			wr_errs++;
			$display("memory saw %0d writes but %0d were expected", wr_cnt, N_WR);
		end
	endtask

endmodule

/* test/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

	localparam logic [1:0] OP_RD = 2'd0;
	localparam logic [1:0] OP_WR = 2'd1;
	localparam logic [1:0] OP_HALT = 2'd2;

	logic CLK, nRST;
	logic dmemREN, dmemWEN, halt;
	word_t dmemaddr, dmemstore, dmemload, exp_load;
	logic dhit, flushed;
	logic dwait, dREN, dWEN;
	word_t dload, daddr, dstore;

	word_t mem [1024];
	logic [1:0] stall = 2'd0;  // cycles of dwait left before the transfer
	integer seed = 32'h1b46_cdaa;

	logic [1:0] op_kind [$];
	word_t op_addr [$];
	word_t op_data [$];
	word_t op_exp [$];
	int timeouts = 0;
	bit timed_out = 1'b0;

	dcache u_dut (.*);

	dcache_monitor u_mon (.*);

	bind dcache dcache_chk u_chk (
		.CLK(CLK),
		.nRST(nRST),
		.dREN(dREN),
		.dWEN(dWEN),
		.dwait(dwait),
		.daddr(daddr),
		.flushed(flushed)
	);

	function automatic word_t mem_init(word_t a);
		return a ^ 32'h5a5a_0000;
	endfunction

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// memory model
	initial begin
		for (int i = 0; i < 1024; i++) begin
			mem[i] = mem_init(word_t'(i) << 2);
		end
	end

	assign dwait = (stall != 2'd0);
	assign dload = mem[daddr[11:2]];

	always @(posedge CLK) begin
		if (!nRST) begin
			stall <= 2'd0;
		end else if (dREN || dWEN) begin
			if (stall != 2'd0) begin
				stall <= stall - 2'd1;
			end else begin
				if (dWEN) mem[daddr[11:2]] <= dstore;
				stall <= 2'($random(seed));  // 0 to 3 for the next transfer
			end
		end
	end

	task automatic add_op(logic [1:0] kind, word_t a, word_t d, word_t e);
		op_kind.push_back(kind);
		op_addr.push_back(a);
		op_data.push_back(d);
		op_exp.push_back(e);
	endtask

	// wait for dhit or for flushed after a halt
	task automatic wait_done(bit for_flush, output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < 200) begin
			@(negedge CLK);
			ok = for_flush ? flushed : dhit;
			n++;
		end
		if (!ok) begin
			timeouts++;
			if (for_flush) $display("timeout: flushed did not rise within 200 cycles");
			else $display("timeout: no dhit within 200 cycles for address %h", dmemaddr);
		end
	endtask

	initial begin
		bit ok;
		int errors;
		dmemREN = 1'b0;
		dmemWEN = 1'b0;
		halt = 1'b0;
		dmemaddr = '0;
		dmemstore = '0;
		exp_load = '0;
		nRST = 1'b0;

		add_op(OP_RD, 32'h008, 0, mem_init(32'h008));  // cold miss
		add_op(OP_RD, 32'h00c, 0, mem_init(32'h00c));
		add_op(OP_WR, 32'h00c, 32'hcafe_0001, 0);
		add_op(OP_RD, 32'h00c, 0, 32'hcafe_0001);
		// set 2 sees tags A B A C A
		add_op(OP_RD, 32'h010, 0, mem_init(32'h010));
		add_op(OP_RD, 32'h050, 0, mem_init(32'h050));
		add_op(OP_RD, 32'h010, 0, mem_init(32'h010));
		add_op(OP_WR, 32'h014, 32'hbeef_0014, 0);  // A made dirty so evicting it shows on the bus
		add_op(OP_RD, 32'h090, 0, mem_init(32'h090));
		add_op(OP_RD, 32'h010, 0, mem_init(32'h010));  // A kept while C replaced B
		// set 3 dirty block pushed out by two other tags
		add_op(OP_WR, 32'h018, 32'hd00d_0000, 0);
		add_op(OP_WR, 32'h01c, 32'hd00d_0004, 0);
		add_op(OP_RD, 32'h058, 0, mem_init(32'h058));
		add_op(OP_RD, 32'h098, 0, mem_init(32'h098));
		add_op(OP_RD, 32'h018, 0, 32'hd00d_0000);
		add_op(OP_RD, 32'h01c, 0, 32'hd00d_0004);
		add_op(OP_WR, 32'h094, 32'hc0c0_0094, 0);  // way 1 dirty for the flush
		add_op(OP_HALT, 0, 0, 0);

		repeat (3) @(posedge CLK);
		nRST <= 1'b1;

		for (int i = 0; i < op_kind.size() && !timed_out; i++) begin
			@(posedge CLK);
			dmemaddr <= op_addr[i];
			dmemstore <= op_data[i];
			exp_load <= op_exp[i];
			dmemREN <= (op_kind[i] == OP_RD);
			dmemWEN <= (op_kind[i] == OP_WR);
			halt <= (op_kind[i] == OP_HALT);
			wait_done(op_kind[i] == OP_HALT, ok);
			if (!ok) timed_out = 1'b1;
			@(posedge CLK);
			dmemREN <= 1'b0;
			dmemWEN <= 1'b0;
		end
		repeat (4) @(posedge CLK);  // flushed must stay up

		u_mon.check_end();
		errors = u_mon.load_errs + u_mon.wr_errs + u_dut.u_chk.fails + timeouts;
		$display("load errors %0d, write errors %0d, assertion failures %0d, timeouts %0d",
			u_mon.load_errs, u_mon.wr_errs, u_dut.u_chk.fails, timeouts);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
